// ==== Makefile ====
# Verilator flow for the PWM generator, run from the project root

VERILATOR  ?= verilator
TOP        ?= tb_pwm
FLIST      ?= all.f
BUILD_DIR  ?= obj_dir
JOBS       ?= 4
VFLAGS     ?= --binary --timing --assert -j $(JOBS)
LINT_FLAGS ?= --lint-only --timing -Wall

SIM  := $(BUILD_DIR)/V$(TOP)
SRCS := $(wildcard hw/*.sv tb/*.sv)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

# exit status of the simulation is the verdict
run: $(SIM) tb/pwm_cases.txt
	$(SIM)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== all.f ====
hw/pwm_pkg.sv
hw/carrier_counter.sv
hw/event_mask.sv
hw/compare_channel.sv
hw/dead_time.sv
hw/pwm_top.sv
tb/pwm_asserts.sv
tb/tb_pwm.sv

// ==== hw/carrier_counter.sv ====
`timescale 1ns/10ps

module carrier_counter (
    input  logic                 clk,
    input  logic                 rst,
    // last count value of the carrier
    input  pwm_pkg::carr_count_t period,
    // start value, sets the phase shift between carriers
    input  pwm_pkg::carr_count_t init_value,
    input  pwm_pkg::count_mode_t count_mode,
    // pwm_on and carr_on combined at the top
    input  logic                 run,
    output pwm_pkg::carr_count_t count,
    output logic                 zero_evt,
    output logic                 period_evt
);

    // direction flag, only used in up-down mode
    logic dir_down;
    logic at_zero;
    logic at_period;

    // --------------------
    // events
    // --------------------
    assign at_zero = (count == '0);
    assign at_period = (count == period);

    // no events while the carrier is parked
    assign zero_evt = run & at_zero;
    assign period_evt = run & at_period;

    // --------------------
    // counter
    // --------------------
    always_ff @(posedge clk) begin
        if (rst || !run) begin
            // parked at the initial value until enabled
            count <= init_value;
            dir_down <= 1'b0;
        end else begin
            case (count_mode)
                pwm_pkg::COUNT_UPDOWN: begin
                    if (dir_down) begin
                        // bottom of the triangle, turn around after one cycle at 0
                        if (at_zero) begin
                            dir_down <= 1'b0;
                            count <= (period == '0) ? '0 : pwm_pkg::carr_count_t'(1);
                        end else begin
                            count <= count - 1'b1;
                        end
                    end else if (count >= period) begin
                        // top of the triangle
                        // a zero period keeps the carrier at 0
                        if (!at_zero) begin
                            dir_down <= 1'b1;
                            count <= count - 1'b1;
                        end
                    end else begin
                        count <= count + 1'b1;
                    end
                end
                default: begin
                    // saw-tooth, 0 .. period then wrap
                    dir_down <= 1'b0;
                    if (count >= period) begin
                        count <= '0;
                    end else begin
                        count <= count + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

// ==== hw/compare_channel.sv ====
`timescale 1ns/10ps

module compare_channel (
    input  logic                                clk,
    input  logic                                rst,
    // counts and zero events of every carrier
    input  pwm_pkg::carr_array_t                counts,
    input  logic [pwm_pkg::NUM_CARRIERS-1:0]    zero_evts,
    // static carrier choice for this channel
    input  pwm_pkg::carr_sel_t                  carr_sel,
    // requested compare value, shadowed below
    input  pwm_pkg::carr_count_t                compare,
    output logic                                pwm_raw
);

    // --------------------
    // carrier select
    // --------------------
    pwm_pkg::carr_count_t sel_count;
    logic sel_zero;
    // compare value in use for the current carrier period
    pwm_pkg::carr_count_t active_cmp;

    assign sel_count = counts[carr_sel];
    assign sel_zero = zero_evts[carr_sel];

    // --------------------
    // shadow compare
    // --------------------
    // new duty only at the zero of the selected carrier,
    // so a running period is never cut short
    // also follows compare while held in reset
    always_ff @(posedge clk) begin
        if (rst || sel_zero) begin
            active_cmp <= compare;
        end
    end

    // --------------------
    // raw pulse
    // --------------------
    // high while the carrier is below the compare value
    // compare of 0 gives no pulse, above period gives full on
    always_ff @(posedge clk) begin
        if (rst) begin
            pwm_raw <= 1'b0;
        end else begin
            pwm_raw <= (sel_count < active_cmp);
        end
    end

endmodule

// ==== hw/dead_time.sv ====
`timescale 1ns/10ps

module dead_time (
    input  logic               clk,
    input  logic               rst,
    // raw pulse from the compare channel
    input  logic               pwm_raw,
    // rising-edge delays in clk cycles
    input  pwm_pkg::dt_count_t dtime_a,
    input  pwm_pkg::dt_count_t dtime_b,
    // polarity, 1 inverts the output
    input  logic               logic_a,
    input  logic               logic_b,
    output logic               pwm_a,
    output logic               pwm_b
);

    // cycles the raw pulse has been high or low, saturating
    pwm_pkg::dt_count_t cnt_a;
    pwm_pkg::dt_count_t cnt_b;
    // drives before polarity, high means switch on
    logic drive_a;
    logic drive_b;

    // --------------------
    // delay counters
    // --------------------
    // A restarts on the rising edge of pwm_raw, B on the falling edge
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_a <= '0;
            cnt_b <= '0;
        end else begin
            if (!pwm_raw) begin
                cnt_a <= '0;
            end else if (cnt_a != '1) begin
                cnt_a <= cnt_a + 1'b1;
            end
            if (pwm_raw) begin
                cnt_b <= '0;
            end else if (cnt_b != '1) begin
                cnt_b <= cnt_b + 1'b1;
            end
        end
    end

    // --------------------
    // drives
    // --------------------
    // turn on only after the dead time, turn off at once
    assign drive_a = pwm_raw & (cnt_a >= dtime_a);
    assign drive_b = ~pwm_raw & (cnt_b >= dtime_b);

    // --------------------
    // output stage
    // --------------------
    // one cycle latency, polarity applied in the flops
    always_ff @(posedge clk) begin
        if (rst) begin
            // inactive drives, outputs sit at their off level
            pwm_a <= logic_a;
            pwm_b <= logic_b;
        end else begin
            pwm_a <= drive_a ^ logic_a;
            pwm_b <= drive_b ^ logic_b;
        end
    end

endmodule

// ==== hw/event_mask.sv ====
`timescale 1ns/10ps

module event_mask (
    input  logic                clk,
    input  logic                rst,
    // carrier 0 events
    input  logic                zero_evt,
    input  logic                period_evt,
    input  pwm_pkg::mask_mode_t mask_mode,
    // divide by event_div+1
    input  pwm_pkg::evt_count_t event_div,
    input  logic                int_on,
    output logic                interrupt
);

    logic evt_sel;
    logic evt_last;
    // selected events seen since the last interrupt
    pwm_pkg::evt_count_t evt_cnt;

    // --------------------
    // event filter
    // --------------------
    // a cycle with both events counts once in MASK_BOTH
    always_comb begin
        case (mask_mode)
            pwm_pkg::MASK_ZERO:   evt_sel = zero_evt;
            pwm_pkg::MASK_PERIOD: evt_sel = period_evt;
            pwm_pkg::MASK_BOTH:   evt_sel = zero_evt | period_evt;
            default:              evt_sel = 1'b0;
        endcase
    end

    // this event completes the group of event_div+1
    assign evt_last = evt_sel && (evt_cnt == event_div);

    // --------------------
    // divider and pulse
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            evt_cnt <= '0;
            interrupt <= 1'b0;
        end else begin
            // divider keeps running with the interrupt off
            interrupt <= evt_last & int_on;
            if (evt_last) begin
                evt_cnt <= '0;
            end else if (evt_sel) begin
                evt_cnt <= evt_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== hw/pwm_pkg.sv ====
package pwm_pkg;

    // --------------------
    // widths
    // --------------------
    // carrier counters, periods and compare values
    localparam int CARR_WIDTH = 16;
    // dead-time delay counters
    localparam int DT_WIDTH = 8;
    // event divider for the interrupt
    localparam int EVT_WIDTH = 3;

    // --------------------
    // scaling
    // --------------------
    localparam int NUM_CARRIERS = 2;
    localparam int NUM_CHANNELS = 2;
    // carrier index width, at least one bit
    localparam int CARR_SEL_WIDTH = (NUM_CARRIERS > 1) ? $clog2(NUM_CARRIERS) : 1;

    // --------------------
    // types
    // --------------------
    typedef logic [CARR_WIDTH-1:0] carr_count_t;
    typedef logic [DT_WIDTH-1:0] dt_count_t;
    // interrupt fires every value+1 selected events
    typedef logic [EVT_WIDTH-1:0] evt_count_t;
    typedef logic [CARR_SEL_WIDTH-1:0] carr_sel_t;

    // saw-tooth or triangle carrier
    typedef enum logic {
        COUNT_UP     = 1'b0,
        COUNT_UPDOWN = 1'b1
    } count_mode_t;

    // which carrier events feed the interrupt divider
    typedef enum logic [1:0] {
        MASK_ZERO   = 2'd0,
        MASK_PERIOD = 2'd1,
        MASK_BOTH   = 2'd2
    } mask_mode_t;

    // one count per carrier
    typedef carr_count_t [NUM_CARRIERS-1:0] carr_array_t;
    // one output bit per compare channel
    typedef logic [NUM_CHANNELS-1:0] chan_bits_t;

endpackage

// ==== hw/pwm_top.sv ====
`timescale 1ns/10ps

module pwm_top (
    input  logic                                                clk,
    input  logic                                                rst,
    // global enables
    input  logic                                                pwm_on,
    input  logic                                                int_on,
    // per carrier
    input  pwm_pkg::carr_array_t                                period,
    input  pwm_pkg::carr_array_t                                init_value,
    input  pwm_pkg::count_mode_t [pwm_pkg::NUM_CARRIERS-1:0]    count_mode,
    input  logic [pwm_pkg::NUM_CARRIERS-1:0]                    carr_on,
    // interrupt setup, carrier 0 only
    input  pwm_pkg::evt_count_t                                 event_div,
    input  pwm_pkg::mask_mode_t                                 mask_mode,
    // per channel
    input  pwm_pkg::carr_sel_t [pwm_pkg::NUM_CHANNELS-1:0]      carr_sel,
    input  pwm_pkg::carr_count_t [pwm_pkg::NUM_CHANNELS-1:0]    compare,
    input  pwm_pkg::dt_count_t [pwm_pkg::NUM_CHANNELS-1:0]      dtime_a,
    input  pwm_pkg::dt_count_t [pwm_pkg::NUM_CHANNELS-1:0]      dtime_b,
    input  pwm_pkg::chan_bits_t                                 logic_a,
    input  pwm_pkg::chan_bits_t                                 logic_b,
    output pwm_pkg::chan_bits_t                                 pwm_a,
    output pwm_pkg::chan_bits_t                                 pwm_b,
    output logic                                                interrupt
);

    pwm_pkg::carr_array_t counts;
    logic [pwm_pkg::NUM_CARRIERS-1:0] carr_run;
    logic [pwm_pkg::NUM_CARRIERS-1:0] zero_evts;
    logic [pwm_pkg::NUM_CARRIERS-1:0] period_evts;
    pwm_pkg::chan_bits_t pwm_raw;
    // channels sit in reset while pwm is off, outputs at their off level
    logic chan_rst;

    assign chan_rst = rst | ~pwm_on;

    // --------------------
    // carriers
    // --------------------
    for (genvar c = 0; c < pwm_pkg::NUM_CARRIERS; c++) begin : g_carr
        assign carr_run[c] = pwm_on & carr_on[c];

        carrier_counter u_carr (
            .clk,
            .rst,
            .period     (period[c]),
            .init_value (init_value[c]),
            .count_mode (count_mode[c]),
            .run        (carr_run[c]),
            .count      (counts[c]),
            .zero_evt   (zero_evts[c]),
            .period_evt (period_evts[c])
        );
    end

    // interrupt from carrier 0 events
    event_mask u_evt (
        .clk,
        .rst,
        .zero_evt   (zero_evts[0]),
        .period_evt (period_evts[0]),
        .mask_mode,
        .event_div,
        .int_on,
        .interrupt
    );

    // --------------------
    // channels
    // --------------------
    for (genvar ch = 0; ch < pwm_pkg::NUM_CHANNELS; ch++) begin : g_chan
        compare_channel u_cmp (
            .clk,
            .rst       (chan_rst),
            .counts,
            .zero_evts,
            .carr_sel  (carr_sel[ch]),
            .compare   (compare[ch]),
            .pwm_raw   (pwm_raw[ch])
        );

        dead_time u_dt (
            .clk,
            .rst     (chan_rst),
            .pwm_raw (pwm_raw[ch]),
            .dtime_a (dtime_a[ch]),
            .dtime_b (dtime_b[ch]),
            .logic_a (logic_a[ch]),
            .logic_b (logic_b[ch]),
            .pwm_a   (pwm_a[ch]),
            .pwm_b   (pwm_b[ch])
        );
    end

endmodule

// ==== tb/pwm_asserts.sv ====
`timescale 1ns/10ps

module pwm_asserts (
    input logic                 clk,
    input logic                 rst,
    // registered dead-time drives with the polarity taken out
    input logic                 excl_a,
    input logic                 excl_b,
    // carrier bounds while running
    input logic                 run,
    input pwm_pkg::carr_count_t count,
    input pwm_pkg::carr_count_t period,
    // single-cycle pulse
    input logic                 pulse
);

    // --------------------
    // properties
    // --------------------
    a_excl: assert property (@(posedge clk) disable iff (rst) !(excl_a && excl_b))
        else $error("drive A and drive B active in the same cycle");

    // a running carrier stays within 0 .. period
    a_bound: assert property (@(posedge clk) disable iff (rst) run |-> (count <= period))
        else $error("carrier count %h above period %h", count, period);

    a_pulse: assert property (@(posedge clk) disable iff (rst) pulse |=> !pulse)
        else $error("interrupt high for two cycles in a row");

endmodule

bind dead_time pwm_asserts u_dt_chk (
    .clk, .rst, .excl_a (pwm_a ^ logic_a), .excl_b (pwm_b ^ logic_b),
    .run (1'b0), .count ('0), .period ('0), .pulse (1'b0)
);

bind carrier_counter pwm_asserts u_carr_chk (
    .clk, .rst, .excl_a (1'b0), .excl_b (1'b0),
    .run, .count, .period, .pulse (1'b0)
);

bind event_mask pwm_asserts u_evt_chk (
    .clk, .rst, .excl_a (1'b0), .excl_b (1'b0),
    .run (1'b0), .count ('0), .period ('0), .pulse (interrupt)
);

// ==== tb/pwm_cases.txt ====
# hex columns: p0 i0 m0 on0 p1 i1 m1 on1 pwm_on int_on div mask | per channel 0 then 1:
# sel cmp dta dtb la lb | run_len mid_cmp rnd_init (m: 0 up 1 updown, mask: 0 zero 1 per 2 both)
0009 0000 0 1 000f 0000 0 1 1 1 0 0 0 0004 00 00 0 0 1 0008 00 00 0 0 0064 0007 0
0007 0000 0 1 0007 0000 0 1 1 1 1 0 0 0000 00 00 0 0 0 0009 00 00 0 0 0050 0003 0
000a 0000 1 1 000a 0005 1 1 1 1 2 1 0 0004 00 00 0 0 1 0004 00 00 0 0 0078 0006 0
000c 0000 1 1 0010 0000 1 1 1 1 1 2 1 0006 00 00 0 0 0 0003 00 00 0 0 0080 0009 1
0013 0000 0 1 0013 0000 1 1 1 1 0 0 0 0008 02 03 0 0 1 000a 04 01 0 0 00a0 0005 0
000f 0000 0 1 000f 0004 0 1 1 1 3 0 0 0006 01 01 1 0 1 0006 02 02 0 1 0064 000c 0
000f 0003 0 1 000f 0004 1 1 0 1 0 0 0 0006 01 01 1 1 1 0006 00 00 0 1 0030 0002 0
0009 0000 0 1 0009 0004 0 0 1 1 0 0 0 0005 00 00 0 0 1 0006 00 00 0 0 0050 0002 0
0005 0000 0 1 0005 0000 0 1 1 0 0 2 0 0003 00 00 0 0 1 0003 00 00 0 0 0040 0001 0
0004 0000 1 1 0006 0002 0 1 1 1 7 1 0 0002 01 00 0 0 1 0004 00 01 1 1 0060 0003 0
0001 0000 0 1 0003 0000 1 1 1 1 1 2 0 0001 00 00 0 0 1 0002 00 00 0 0 0030 0002 0
0009 0000 0 1 0009 0000 0 1 1 1 4 1 0 0005 06 06 0 0 0 0003 0a 00 1 0 0064 0008 1
0008 0008 1 1 0008 0000 1 1 1 1 2 0 1 0004 02 02 0 0 0 0004 00 00 0 0 0064 0000 0
0011 0002 0 1 000b 0000 1 1 1 1 5 2 1 0007 03 02 0 1 0 000c 01 03 1 1 00c8 0004 1

// ==== tb/tb_pwm.sv ====
`timescale 1ns/10ps

module tb_pwm;

    localparam int NC = pwm_pkg::NUM_CARRIERS;
    localparam int NCH = pwm_pkg::NUM_CHANNELS;
    localparam int RST_CYCLES = 8;
    // fields per case line as listed at the top of the case file
    localparam int NFIELDS = 27;
    localparam int MAX_CASES = 32;
    localparam string CASE_FILE = "tb/pwm_cases.txt";

    // --------------------
    // DUT ports
    // --------------------
    logic clk;
    logic rst;
    logic pwm_on;
    logic int_on;
    pwm_pkg::carr_array_t period;
    pwm_pkg::carr_array_t init_value;
    pwm_pkg::count_mode_t [NC-1:0] count_mode;
    logic [NC-1:0] carr_on;
    pwm_pkg::evt_count_t event_div;
    pwm_pkg::mask_mode_t mask_mode;
    pwm_pkg::carr_sel_t [NCH-1:0] carr_sel;
    pwm_pkg::carr_count_t [NCH-1:0] compare;
    pwm_pkg::dt_count_t [NCH-1:0] dtime_a;
    pwm_pkg::dt_count_t [NCH-1:0] dtime_b;
    pwm_pkg::chan_bits_t logic_a;
    pwm_pkg::chan_bits_t logic_b;
    pwm_pkg::chan_bits_t pwm_a;
    pwm_pkg::chan_bits_t pwm_b;
    logic interrupt;

    // case table and run bookkeeping
    int cfg [MAX_CASES][NFIELDS];
    int ncases;
    int total_len;
    int case_idx;
    int cycles;
    int cycle_limit;
    int seed;

    // --------------------
    // reference model state
    // --------------------
    pwm_pkg::carr_count_t ref_cnt [NC];
    logic ref_down [NC];
    pwm_pkg::carr_count_t ref_active [NCH];
    logic ref_raw [NCH];
    // saturating count of cycles the raw pulse has held its level
    pwm_pkg::dt_count_t ref_age [NCH];
    pwm_pkg::evt_count_t ref_evt;
    pwm_pkg::chan_bits_t exp_a;
    pwm_pkg::chan_bits_t exp_b;
    logic exp_irq;

    pwm_top dut0 (
        .clk, .rst, .pwm_on, .int_on, .period, .init_value, .count_mode, .carr_on,
        .event_div, .mask_mode, .carr_sel, .compare, .dtime_a, .dtime_b,
        .logic_a, .logic_b, .pwm_a, .pwm_b, .interrupt
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // run length guard with a limit set once the cases are known
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Errors found");
            $fatal(1, "run still going after %0d cycles, limit reached", cycles);
        end
    end

    task automatic fail_run(input string why);
        $display("Errors found");
        $fatal(1, "%s", why);
    endtask

    task automatic check_pwm(input string name, input pwm_pkg::chan_bits_t exp,
                             input pwm_pkg::chan_bits_t act);
        if (act !== exp) begin
            $display("ERR %s expected %h actual %h (case %0d, cycle %0d)",
                     name, exp, act, case_idx, cycles);
            fail_run("pwm output mismatch");
        end
    endtask

    task automatic check_irq(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s expected %h actual %h (case %0d, cycle %0d)",
                     name, exp, act, case_idx, cycles);
            fail_run("interrupt mismatch");
        end
    endtask

    // --------------------
    // case file
    // --------------------
    task automatic read_cases();
        int fd;
        int n;
        int bad_line;
        int line_no;
        string line;
        int f [NFIELDS];
        bad_line = 0;
        line_no = 0;
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            fail_run("cannot open the case file tb/pwm_cases.txt");
        end else begin
            while ($fgets(line, fd) > 0) begin
                line_no++;
                n = $sscanf(line, "%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                            f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16],
                            f[17], f[18], f[19], f[20], f[21], f[22], f[23], f[24],
                            f[25], f[26]);
                // comment lines scan nothing
                if (n == NFIELDS && ncases < MAX_CASES) begin
                    for (int k = 0; k < NFIELDS; k++) begin
                        cfg[ncases][k] = f[k];
                    end
                    total_len += f[24];
                    ncases++;
                end else if (n > 0 && bad_line == 0) begin
                    bad_line = line_no;
                end
            end
            $fclose(fd);
            if (bad_line != 0) begin
                fail_run($sformatf("case file line %0d is malformed or too many", bad_line));
            end else if (ncases == 0) begin
                fail_run("case file holds no cases");
            end
        end
    endtask

    task automatic apply_case(input int n);
        int b;
        for (int c = 0; c < NC; c++) begin
            b = c * 4;
            period[c] = pwm_pkg::carr_count_t'(cfg[n][b]);
            init_value[c] = pwm_pkg::carr_count_t'(cfg[n][b+1]);
            count_mode[c] = pwm_pkg::count_mode_t'(cfg[n][b+2][0]);
            carr_on[c] = cfg[n][b+3][0];
        end
        pwm_on = cfg[n][8][0];
        int_on = cfg[n][9][0];
        event_div = pwm_pkg::evt_count_t'(cfg[n][10]);
        mask_mode = pwm_pkg::mask_mode_t'(cfg[n][11][1:0]);
        for (int ch = 0; ch < NCH; ch++) begin
            b = 12 + ch * 6;
            carr_sel[ch] = pwm_pkg::carr_sel_t'(cfg[n][b]);
            compare[ch] = pwm_pkg::carr_count_t'(cfg[n][b+1]);
            dtime_a[ch] = pwm_pkg::dt_count_t'(cfg[n][b+2]);
            dtime_b[ch] = pwm_pkg::dt_count_t'(cfg[n][b+3]);
            logic_a[ch] = cfg[n][b+4][0];
            logic_b[ch] = cfg[n][b+5][0];
        end
    endtask

    // --------------------
    // reference model called once per rising edge
    // --------------------
    task automatic update_model();
        logic chan_rst;
        logic [NC-1:0] run;
        logic [NC-1:0] zero;
        logic [NC-1:0] top;
        logic sel;
        logic raw_next;
        logic drive_a;
        logic drive_b;
        chan_rst = rst | ~pwm_on;
        // events come from the counts before this edge
        for (int c = 0; c < NC; c++) begin
            run[c] = pwm_on & carr_on[c];
            zero[c] = run[c] && (ref_cnt[c] == '0);
            top[c] = run[c] && (ref_cnt[c] == period[c]);
        end
        case (mask_mode)
            pwm_pkg::MASK_ZERO:   sel = zero[0];
            pwm_pkg::MASK_PERIOD: sel = top[0];
            pwm_pkg::MASK_BOTH:   sel = zero[0] | top[0];
            default:              sel = 1'b0;
        endcase
        // interrupt every event_div+1 selected events
        exp_irq = 1'b0;
        if (rst) begin
            ref_evt = '0;
        end else if (sel && ref_evt == event_div) begin
            ref_evt = '0;
            exp_irq = int_on;
        end else if (sel) begin
            ref_evt = ref_evt + 3'd1;
        end
        for (int ch = 0; ch < NCH; ch++) begin
            // on only after the dead time at this level
            drive_a = ref_raw[ch] && (ref_age[ch] >= dtime_a[ch]);
            drive_b = !ref_raw[ch] && (ref_age[ch] >= dtime_b[ch]);
            if (chan_rst) begin
                ref_raw[ch] = 1'b0;
                ref_age[ch] = '0;
                ref_active[ch] = compare[ch];
                exp_a[ch] = logic_a[ch];
                exp_b[ch] = logic_b[ch];
            end else begin
                raw_next = ref_cnt[carr_sel[ch]] < ref_active[ch];
                if (raw_next != ref_raw[ch]) begin
                    ref_age[ch] = '0;
                end else if (ref_age[ch] != '1) begin
                    ref_age[ch] = ref_age[ch] + 8'd1;
                end
                exp_a[ch] = drive_a ^ logic_a[ch];
                exp_b[ch] = drive_b ^ logic_b[ch];
                // shadow reload at the selected zero
                if (zero[carr_sel[ch]]) begin
                    ref_active[ch] = compare[ch];
                end
                ref_raw[ch] = raw_next;
            end
        end
        // carriers go last so the channels above saw the old counts
        for (int c = 0; c < NC; c++) begin
            if (rst || !run[c]) begin
                ref_cnt[c] = init_value[c];
                ref_down[c] = 1'b0;
            end else if (count_mode[c] == pwm_pkg::COUNT_UPDOWN) begin
                if (ref_down[c] && ref_cnt[c] == '0) begin
                    ref_down[c] = 1'b0;
                    ref_cnt[c] = 16'd1;
                end else if (ref_down[c]) begin
                    ref_cnt[c] = ref_cnt[c] - 16'd1;
                end else if (ref_cnt[c] == period[c]) begin
                    ref_down[c] = 1'b1;
                    ref_cnt[c] = ref_cnt[c] - 16'd1;
                end else begin
                    ref_cnt[c] = ref_cnt[c] + 16'd1;
                end
            end else begin
                ref_cnt[c] = (ref_cnt[c] == period[c]) ? '0 : ref_cnt[c] + 16'd1;
            end
        end
    endtask

    // one clock and a compare at the settled outputs
    task automatic step();
        @(posedge clk);
        update_model();
        #1;
        // A and B never on together when seen through the polarity bits
        check_pwm("pwm_a_b_overlap", '0, (pwm_a ^ logic_a) & (pwm_b ^ logic_b));
        check_pwm("pwm_a", exp_a, pwm_a);
        check_pwm("pwm_b", exp_b, pwm_b);
        check_irq("interrupt", exp_irq, interrupt);
    endtask

    task automatic run_case(input int n);
        int len;
        int half;
        int unsigned draw;
        case_idx = n;
        rst = 1'b1;
        apply_case(n);
        // random phase kept within the period
        if (cfg[n][26] != 0) begin
            for (int c = 0; c < NC; c++) begin
                draw = $random(seed);
                init_value[c] = pwm_pkg::carr_count_t'(draw % (int'(period[c]) + 1));
            end
        end
        repeat (RST_CYCLES) step();
        rst = 1'b0;
        len = cfg[n][24];
        half = len / 2;
        for (int k = 0; k < len; k++) begin
            // new duty mid-run is held back by the shadow register
            if (k == half) begin
                for (int ch = 0; ch < NCH; ch++) begin
                    compare[ch] = pwm_pkg::carr_count_t'(cfg[n][25]);
                end
            end
            step();
        end
    endtask

    initial begin
        seed = 84195;
        cycles = 0;
        cycle_limit = 0;
        ncases = 0;
        total_len = 0;
        case_idx = 0;
        rst = 1'b1;
        pwm_on = 1'b0;
        int_on = 1'b0;
        period = '0;
        init_value = '0;
        count_mode = '0;
        carr_on = '0;
        event_div = '0;
        mask_mode = pwm_pkg::MASK_ZERO;
        carr_sel = '0;
        compare = '0;
        dtime_a = '0;
        dtime_b = '0;
        logic_a = '0;
        logic_b = '0;
        read_cases();
        cycle_limit = (total_len + (ncases + 1) * RST_CYCLES) * 3 / 2;
        for (int n = 0; n < ncases; n++) begin
            run_case(n);
        end
        $display("No errors");
        $finish;
    end

endmodule
